/* Bender.yml */
package:
  name: tetris_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pieceTypesPkg.sv
      - rtl/gameCtrlPkg.sv
      - rtl/pieceSpawner.sv
      - rtl/pieceDrop.sv
      - rtl/boardStore.sv
      - rtl/gameCtrl.sv
      - rtl/tetrisCore.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tetrisCoreTb.sv

/* list.f */
+incdir+rtl
rtl/pieceTypesPkg.sv
rtl/gameCtrlPkg.sv
rtl/pieceSpawner.sv
rtl/pieceDrop.sv
rtl/boardStore.sv
rtl/gameCtrl.sv
rtl/tetrisCore.sv
test/tetrisCoreTb.sv

/* rtl/boardStore.sv */
`timescale 1ns/1ps
`include "tetris_config.svh"

module boardStore import pieceTypesPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  clear,
    input  logic  lock,
    input  logic  show,
    input  boardT pieceMask,
    output boardT board,
    output logic  overlap,
    output boardT frame
);

    boardT settled;
    boardT shownPiece;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            settled <= '0;
        end else if (clear) begin
            settled <= '0;  // New game
        end else if (lock) begin
            settled <= settled | pieceMask;  // Merge landed piece
        end
    end

    assign board = settled;

    // Checked by the controller right after a spawn
    assign overlap = |(pieceMask & settled);

    // Active piece hidden while no game runs
    assign shownPiece = show ? pieceMask : '0;
    assign frame      = settled | shownPiece;

    // Start is only accepted outside of the lock cycle
    clearLockExclusive: assert property (
        @(posedge clk) disable iff (rst) !(clear && lock)
    ) else $error("Board clear and lock in the same cycle");

endmodule

/* rtl/gameCtrl.sv */
`timescale 1ns/1ps
`include "tetris_config.svh"

module gameCtrl import gameCtrlPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        landed,
    input  logic        overlap,
    output logic        spawn,
    output logic        lock,
    output logic        fallEn,
    output logic        show,
    output logic        gameOver,
    output logic [15:0] pieceCount
);

    gameStateT state;
    gameStateT stateNext;
    logic      firstFall;  // First FALL cycle after a spawn
    logic      startGame;
    logic      spawnBlocked;

    assign startGame    = start && (state == IDLE || state == OVER);
    assign spawnBlocked = firstFall && overlap;

    always_comb begin
        stateNext = state;
        case (state)
            IDLE, OVER: begin
                if (start) begin
                    stateNext = SPAWN;
                end
            end
            SPAWN: stateNext = FALL;
            FALL: begin
                if (spawnBlocked) begin
                    stateNext = OVER;  // No room for the new piece
                end else if (landed) begin
                    stateNext = LOCK;
                end
            end
            LOCK:    stateNext = SPAWN;
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            firstFall  <= 1'b0;
            pieceCount <= '0;
        end else begin
            state     <= stateNext;
            firstFall <= state == SPAWN;
            if (startGame) begin
                pieceCount <= '0;
            end else if (state == LOCK) begin
                pieceCount <= pieceCount + 16'd1;
            end
        end
    end

    assign spawn    = state == SPAWN;
    assign lock     = state == LOCK;
    assign show     = state != IDLE && state != OVER;
    assign gameOver = state == OVER;

    // Held off after a landing and on a blocked spawn
    // so that at most one landed pulse reaches FALL
    assign fallEn = state == FALL && !landed && !spawnBlocked;

    landedInFall: assert property (
        @(posedge clk) disable iff (rst) landed |-> state == FALL
    ) else $error("Landed pulse outside of FALL");

endmodule

/* rtl/gameCtrlPkg.sv */
`include "tetris_config.svh"

package gameCtrlPkg;

    // Controller states
    typedef enum logic [2:0] {
        IDLE  = 3'd0,  // Waiting for the first start
        SPAWN = 3'd1,  // One cycle, new piece gets captured
        FALL  = 3'd2,  // Piece drops on gravity ticks
        LOCK  = 3'd3,  // One cycle, piece merges into board
        OVER  = 3'd4   // Spawn hit settled cells
    } gameStateT;

endpackage

/* rtl/pieceDrop.sv */
`timescale 1ns/1ps
`include "tetris_config.svh"

module pieceDrop import pieceTypesPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  spawn,
    input  pieceT nextPiece,
    input  logic  fallEn,
    input  logic  tick,
    input  boardT board,
    output boardT pieceMask,
    output pieceT activePiece,
    output logic  landed,
    output logic  maxReached
);

    pieceT  curPiece;
    rowIdxT row;
    rowIdxT floorRow;
    boardT  belowMask;
    logic   hitFloor;
    logic   hitCells;

    // Lowest legal top row for a shape
    function automatic rowIdxT floorLimit(input pieceT p);
        rowIdxT height;
        case (p)
            LINE:      height = 5'd4;
            L, REV_L:  height = 5'd3;
            default:   height = 5'd2;  // Square, S, Z, T
        endcase
        return rowIdxT'(`BOARD_ROWS) - height;
    endfunction

    // Cells of shape p with its top edge on row r
    function automatic boardT shapeMask(input pieceT p, input rowIdxT r);
        boardT m;
        m = '0;
        case (p)
            LINE: begin
                m[r][`SPAWN_COL]         = 1'b1;
                m[r + 5'd1][`SPAWN_COL]  = 1'b1;
                m[r + 5'd2][`SPAWN_COL]  = 1'b1;
                m[r + 5'd3][`SPAWN_COL]  = 1'b1;
            end
            SQUARE: begin
                m[r][`SPAWN_COL +: 2]        = 2'b11;
                m[r + 5'd1][`SPAWN_COL +: 2] = 2'b11;
            end
            L: begin
                m[r][`SPAWN_COL]             = 1'b1;
                m[r + 5'd1][`SPAWN_COL]      = 1'b1;
                m[r + 5'd2][`SPAWN_COL +: 2] = 2'b11;  // Foot to the right
            end
            REV_L: begin
                m[r][`SPAWN_COL + 1]         = 1'b1;
                m[r + 5'd1][`SPAWN_COL + 1]  = 1'b1;
                m[r + 5'd2][`SPAWN_COL +: 2] = 2'b11;  // Foot to the left
            end
            S: begin
                m[r][`SPAWN_COL + 1 +: 2]    = 2'b11;
                m[r + 5'd1][`SPAWN_COL +: 2] = 2'b11;
            end
            Z: begin
                m[r][`SPAWN_COL +: 2]            = 2'b11;
                m[r + 5'd1][`SPAWN_COL + 1 +: 2] = 2'b11;
            end
            default: begin  // T
                m[r][`SPAWN_COL]                 = 1'b1;
                m[r + 5'd1][`SPAWN_COL - 1 +: 3] = 3'b111;
            end
        endcase
        return m;
    endfunction

    assign floorRow  = floorLimit(curPiece);
    assign pieceMask = shapeMask(curPiece, row);
    assign belowMask = shapeMask(curPiece, row + 5'd1);  // Candidate one row down

    assign hitFloor   = row >= floorRow;
    assign hitCells   = |(belowMask & board);  // Any settled cell in the way
    assign maxReached = row == floorRow;

    assign activePiece = curPiece;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            curPiece <= LINE;
            row      <= '0;
            landed   <= 1'b0;
        end else begin
            landed <= 1'b0;  // Single-cycle pulse
            if (spawn) begin
                curPiece <= nextPiece;
                row      <= '0;
            end else if (fallEn && tick) begin
                if (hitFloor || hitCells) begin
                    landed <= 1'b1;  // Row stays put
                end else begin
                    row <= row + 5'd1;
                end
            end
        end
    end

    rowInRange: assert property (
        @(posedge clk) disable iff (rst) row <= floorRow
    ) else $error("Active piece row is below the floor limit");

endmodule

/* rtl/pieceSpawner.sv */
`timescale 1ns/1ps
`include "tetris_config.svh"

module pieceSpawner import pieceTypesPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  spawn,
    output pieceT nextPiece
);

    logic [15:0] lfsr;
    logic [15:0] lfsrMod;
    logic        feedback;

    // Taps 16, 14, 13, 11 in shift-right form
    assign feedback = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lfsr <= `LFSR_SEED;
        end else if (spawn) begin
            lfsr <= {feedback, lfsr[15:1]};  // One step per spawn
        end
    end

    // Current value picks the piece used at the next spawn
    assign lfsrMod   = lfsr % 16'd7;
    assign nextPiece = pieceT'(lfsrMod[2:0]);

    // A zero state would lock the LFSR up for good
    lfsrNonZero: assert property (
        @(posedge clk) disable iff (rst) lfsr != 16'd0
    ) else $error("Spawner LFSR reached the all-zero state");

endmodule

/* rtl/pieceTypesPkg.sv */
`include "tetris_config.svh"

package pieceTypesPkg;

    // The seven falling shapes
    typedef enum logic [2:0] {
        LINE   = 3'd0,  // Vertical 4x1
        SQUARE = 3'd1,  // 2x2 block
        L      = 3'd2,  // Stem with foot to the right
        REV_L  = 3'd3,  // Stem with foot to the left
        S      = 3'd4,
        Z      = 3'd5,
        T      = 3'd6   // Nub on top, bar below
    } pieceT;

    // One board row, bit index is the column
    typedef logic [`BOARD_COLS-1:0] rowMaskT;

    // Whole board, index 0 is the top row
    typedef rowMaskT [`BOARD_ROWS-1:0] boardT;

    // Row position of a piece's top edge
    typedef logic [4:0] rowIdxT;

endpackage

/* rtl/tetrisCore.sv */
`timescale 1ns/1ps
`include "tetris_config.svh"

module tetrisCore import pieceTypesPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        tick,
    output boardT       frame,
    output logic        pieceLanded,
    output logic        gameOver,
    output logic [15:0] pieceCount,
    output pieceT       activePiece
);

    logic  spawn;
    logic  lock;
    logic  fallEn;
    logic  show;
    logic  landed;
    logic  maxReached;
    logic  overlap;
    pieceT nextPiece;
    boardT pieceMask;
    boardT board;

    pieceSpawner pieceSpawner_i (
        .clk       (clk),
        .rst       (rst),
        .spawn     (spawn),
        .nextPiece (nextPiece)
    );

    pieceDrop pieceDrop_i (
        .clk         (clk),
        .rst         (rst),
        .spawn       (spawn),
        .nextPiece   (nextPiece),
        .fallEn      (fallEn),
        .tick        (tick),
        .board       (board),
        .pieceMask   (pieceMask),
        .activePiece (activePiece),
        .landed      (landed),
        .maxReached  (maxReached)
    );

    boardStore boardStore_i (
        .clk       (clk),
        .rst       (rst),
        .clear     (start),  // Board wipes with each start
        .lock      (lock),
        .show      (show),
        .pieceMask (pieceMask),
        .board     (board),
        .overlap   (overlap),
        .frame     (frame)
    );

    gameCtrl gameCtrl_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .landed     (landed),
        .overlap    (overlap),
        .spawn      (spawn),
        .lock       (lock),
        .fallEn     (fallEn),
        .show       (show),
        .gameOver   (gameOver),
        .pieceCount (pieceCount)
    );

    assign pieceLanded = landed;

    // A piece resting on the floor lands on the next accepted tick
    floorLands: assert property (
        @(posedge clk) disable iff (rst) maxReached && fallEn && tick |=> landed
    ) else $error("Piece at floor limit did not land");

endmodule

/* rtl/tetris_config.svh */
`ifndef TETRIS_CONFIG_SVH
`define TETRIS_CONFIG_SVH

// Board geometry, rows counted from the top
`define BOARD_ROWS 20
`define BOARD_COLS 10

// Leftmost column used by the spawn shapes
// (T reaches one column to the left of it)
`define SPAWN_COL 4

// Spawner LFSR start value, must be nonzero
`define LFSR_SEED 16'hACE1

`endif

/* test/tetrisCoreTb.sv */
`timescale 1ns/1ps
`include "tetris_config.svh"

module tetrisCoreTb import pieceTypesPkg::*, gameCtrlPkg::*; ();

    // About 40 pieces of up to ~45 cycles each plus a wide margin
    localparam int timeoutCycles = 20000;
    localparam int pieceLimit    = 80;

    logic        clk;
    logic        rst;
    logic        start;
    logic        tick;
    boardT       frame;
    logic        pieceLanded;
    logic        gameOver;
    logic [15:0] pieceCount;
    pieceT       activePiece;

    int          errors;
    int          checks;
    int          cycleCount;
    logic [15:0] modelLfsr;
    logic [15:0] modelCount;
    boardT       modelBoard;
    pieceT       curPiece;
    int          curRow;
    bit          blockedNext;  // Model predicts a spawn overlap

    tetrisCore tetrisCore_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .tick        (tick),
        .frame       (frame),
        .pieceLanded (pieceLanded),
        .gameOver    (gameOver),
        .pieceCount  (pieceCount),
        .activePiece (activePiece)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Run stopped, no finish after %0d cycles", cycleCount);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic checkFrame(input boardT got, input boardT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH frame got %h exp %h", got, exp);
        end
    endtask

    task automatic checkPiece(input pieceT got, input pieceT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH activePiece got %h exp %h", got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic checkCount(input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH pieceCount got %h exp %h", got, exp);
        end
    endtask

    // Row k of a shape counted down from its top edge
    function automatic rowMaskT shapeRow(input pieceT p, input int k);
        rowMaskT one;
        rowMaskT two;
        one = rowMaskT'(1) << `SPAWN_COL;
        two = rowMaskT'(3) << `SPAWN_COL;
        case (p)
            LINE:   return (k < 4) ? one : '0;
            SQUARE: return (k < 2) ? two : '0;
            L:      return (k < 2) ? one : (k == 2) ? two : '0;
            REV_L:  return (k < 2) ? one << 1 : (k == 2) ? two : '0;
            S:      return (k == 0) ? two << 1 : (k == 1) ? two : '0;
            Z:      return (k == 0) ? two : (k == 1) ? two << 1 : '0;
            default: return (k == 0) ? one : (k == 1) ? rowMaskT'(7) << (`SPAWN_COL - 1) : '0;
        endcase
    endfunction

    function automatic int floorOf(input pieceT p);
        if (p == LINE) return `BOARD_ROWS - 4;
        if (p == L || p == REV_L) return `BOARD_ROWS - 3;
        return `BOARD_ROWS - 2;
    endfunction

    function automatic boardT placeShape(input pieceT p, input int r);
        boardT m;
        m = '0;
        for (int k = 0; k < 4; k++) begin
            if (r + k < `BOARD_ROWS) m[r + k] = shapeRow(p, k);
        end
        return m;
    endfunction

    function automatic bit collides(input pieceT p, input int r);
        return |(placeShape(p, r) & modelBoard);
    endfunction

    function automatic int landingRow(input pieceT p);
        int r;
        r = 0;
        while (r < floorOf(p) && !collides(p, r + 1)) r++;
        return r;
    endfunction

    // Fibonacci LFSR with taps 16 14 13 11 and the piece taken before the shift
    task automatic takeNextPiece(output pieceT p);
        logic [15:0] rem;
        logic        fb;
        rem       = modelLfsr % 16'd7;
        p         = pieceT'(rem[2:0]);
        fb        = modelLfsr[0] ^ modelLfsr[2] ^ modelLfsr[3] ^ modelLfsr[5];
        modelLfsr = {fb, modelLfsr[15:1]};
    endtask

    task automatic step();
        @(negedge clk);
    endtask

    task automatic tickOnce();
        tick = 1'b1;
        step();
        tick = 1'b0;
    endtask

    task automatic pulseStart();
        start = 1'b1;
        step();
        start = 1'b0;
    endtask

    // Piece capture one cycle after SPAWN
    task automatic checkSpawned();
        takeNextPiece(curPiece);
        curRow      = 0;
        blockedNext = collides(curPiece, 0);
        checkPiece(activePiece, curPiece);
        checkFrame(frame, modelBoard | placeShape(curPiece, 0));
    endtask

    // Drops the active piece to rest and checks the lock and the next spawn
    task automatic finishPiece();
        int landRow;
        landRow = landingRow(curPiece);
        while (curRow < landRow) begin
            tickOnce();
            curRow++;
            checkFrame(frame, modelBoard | placeShape(curPiece, curRow));
            checkBit("pieceLanded", pieceLanded, 1'b0);
        end
        tickOnce();
        checkBit("pieceLanded", pieceLanded, 1'b1);
        checkFrame(frame, modelBoard | placeShape(curPiece, curRow));
        modelBoard = modelBoard | placeShape(curPiece, curRow);
        modelCount++;
        step();  // LOCK
        checkBit("pieceLanded", pieceLanded, 1'b0);
        tickOnce();  // Ignored in LOCK, a resting piece would land again
        checkBit("pieceLanded", pieceLanded, 1'b0);
        checkFrame(frame, modelBoard);  // SPAWN shows the merged board only
        checkCount(pieceCount, modelCount);
        step();
        checkSpawned();
    endtask

    task automatic reportTest(input string name, input int errBefore);
        if (errors == errBefore) $display("%-10s passed", name);
        else $display("%-10s failed with %0d errors", name, errors - errBefore);
    endtask

    task automatic resetValues();
        int e;
        e = errors;
        checkFrame(frame, '0);
        checkBit("gameOver", gameOver, 1'b0);
        checkBit("pieceLanded", pieceLanded, 1'b0);
        checkCount(pieceCount, 16'd0);
        reportTest("reset", e);
    endtask

    task automatic firstSpawn();
        int e;
        e = errors;
        pulseStart();
        step();
        checkSpawned();
        reportTest("spawn", e);
    endtask

    task automatic gravityFall();
        int e;
        e = errors;
        repeat (2) begin
            tickOnce();
            curRow++;
            checkFrame(frame, modelBoard | placeShape(curPiece, curRow));
            checkBit("pieceLanded", pieceLanded, 1'b0);
        end
        reportTest("fall", e);
    endtask

    task automatic firstLanding();
        int e;
        e = errors;
        finishPiece();
        checkCount(pieceCount, 16'd1);
        reportTest("landing", e);
    endtask

    task automatic stackPieces();
        int e;
        e = errors;
        for (int i = 0; i < 4 && !blockedNext; i++) finishPiece();
        reportTest("stacking", e);
    endtask

    task automatic runToGameOver();
        int e;
        int n;
        e = errors;
        n = 0;
        while (!blockedNext && n < pieceLimit) begin
            finishPiece();
            n++;
        end
        if (!blockedNext) begin
            errors++;
            $display("Model never predicted a blocked spawn within %0d pieces", pieceLimit);
        end
        step();
        checkBit("gameOver", gameOver, 1'b1);
        checkFrame(frame, modelBoard);
        tickOnce();  // Ignored in OVER
        checkFrame(frame, modelBoard);
        checkBit("pieceLanded", pieceLanded, 1'b0);
        modelBoard = '0;
        modelCount = '0;
        pulseStart();
        checkBit("gameOver", gameOver, 1'b0);
        checkCount(pieceCount, 16'd0);
        step();
        checkSpawned();
        reportTest("gameover", e);
    endtask

    initial begin
        rst         = 1'b1;
        start       = 1'b0;
        tick        = 1'b0;
        errors      = 0;
        checks      = 0;
        cycleCount  = 0;
        modelLfsr   = `LFSR_SEED;
        modelCount  = '0;
        modelBoard  = '0;
        curPiece    = LINE;
        curRow      = 0;
        blockedNext = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        step();

        resetValues();
        firstSpawn();
        gravityFall();
        firstLanding();
        stackPieces();
        runToGameOver();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
